// File: sim.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_core_pkg.sv
hdl/core_ctrl.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/rv_memory.sv
hdl/rv_core_top.sv
sim/rv_core_checker.sv
sim/tb_rv_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "test failed" $(LOG); then exit 1; fi
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module tb_rv_core;

    localparam int NUM_TESTS    = 6;
    localparam int PROG_WORDS   = 6;
    localparam int RESET_CYCLES = 8;
    localparam int HALT_TIMEOUT = 200;

    // RV32I base opcodes
    localparam logic [6:0]  OP_LOAD  = 7'b0000011;
    localparam logic [6:0]  OP_STORE = 7'b0100011;
    localparam logic [6:0]  OP_IMM   = 7'b0010011;
    localparam logic [6:0]  OP_REG   = 7'b0110011;
    localparam logic [31:0] ECALL    = 32'h0000_0073;

    typedef struct packed {
        logic [PROG_WORDS-1:0][31:0] prog;
        logic [31:0]                 init_data;
        logic [31:0]                 exp_addr;
        logic [31:0]                 exp_data;
        logic                        exp_illegal;
    } test_row_t;

    typedef struct packed {
        logic        dmem;
        logic [31:0] addr;
        logic [31:0] data;
    } load_t;

    logic                clk;
    logic                rst_n;
    logic                load_we;
    logic                load_dmem;
    logic [`RV_XLEN-1:0] load_addr;
    logic [`RV_XLEN-1:0] load_data;
    logic [`RV_XLEN-1:0] dbg_addr;
    logic [`RV_XLEN-1:0] dbg_data;
    logic                halted;
    logic                illegal;

    test_row_t tests [NUM_TESTS];
    int        errors;

    rv_core_top i_rv_core_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_we_i   (load_we),
        .load_dmem_i (load_dmem),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .dbg_addr_i  (dbg_addr),
        .dbg_data_o  (dbg_data),
        .halted_o    (halted),
        .illegal_o   (illegal)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] enc_itype(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // sw only, funct3 010
    function automatic logic [31:0] enc_stype(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'b000, rd, OP_REG};
    endfunction

    // marks the checked word so a missing store shows up
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return ~addr ^ 32'h5a5a_0000;
    endfunction

    function automatic test_row_t make_test(input logic [31:0] p0, input logic [31:0] p1,
                                            input logic [31:0] p2, input logic [31:0] p3,
                                            input logic [31:0] init, input logic [31:0] addr,
                                            input logic [31:0] data, input logic ill);
        test_row_t row;
        row.prog        = {ECALL, ECALL, p3, p2, p1, p0};
        row.init_data   = init;
        row.exp_addr    = addr;
        row.exp_data    = data;
        row.exp_illegal = ill;
        return row;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    // one load per reset cycle, the data word at 0 goes last
    task automatic reset_and_load(input test_row_t row);
        load_t loads [RESET_CYCLES];
        for (int i = 0; i < PROG_WORDS; i++) begin
            loads[i] = {1'b0, 32'(i * 4), row.prog[i]};
        end
        loads[6] = {1'b1, row.exp_addr, fill_word(row.exp_addr)};
        loads[7] = {1'b1, 32'd0, row.init_data};
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            load_we   = 1'b1;
            load_dmem = loads[c].dmem;
            load_addr = loads[c].addr;
            load_data = loads[c].data;
            @(posedge clk);
            #1;
        end
        load_we = 1'b0;
        rst_n   = 1'b1;
    endtask

    task automatic wait_halt(output logic timed_out);
        int cycles;
        cycles = 0;
        while (!halted && cycles < HALT_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        timed_out = !halted;
    endtask

    initial begin
        int   err_before;
        logic timed_out;
        clk       = 1'b0;
        rst_n     = 1'b0;
        load_we   = 1'b0;
        load_dmem = 1'b0;
        load_addr = '0;
        load_data = '0;
        dbg_addr  = '0;
        errors    = 0;

        tests[0] = make_test(enc_itype(-12'sd300, 5'd0, 3'b000, 5'd1, OP_IMM),
                             enc_stype(12'd4, 5'd1, 5'd0), ECALL, ECALL,
                             32'h1111_1111, 32'd4, 32'hffff_fed4, 1'b0);
        tests[1] = make_test(enc_itype(12'd0, 5'd0, 3'b010, 5'd2, OP_LOAD),
                             enc_add(5'd3, 5'd2, 5'd2), enc_stype(12'd8, 5'd3, 5'd0), ECALL,
                             32'h9000_0003, 32'd8, 32'h2000_0006, 1'b0);
        // x0 write must be dropped
        tests[2] = make_test(enc_itype(12'd123, 5'd0, 3'b000, 5'd0, OP_IMM),
                             enc_stype(12'd12, 5'd0, 5'd0), ECALL, ECALL,
                             32'h2222_2222, 32'd12, 32'h0000_0000, 1'b0);
        tests[3] = make_test(enc_itype(12'd64, 5'd0, 3'b000, 5'd5, OP_IMM),
                             enc_itype(12'h077, 5'd0, 3'b000, 5'd6, OP_IMM),
                             enc_stype(-12'sd20, 5'd6, 5'd5), ECALL,
                             32'h3333_3333, 32'd44, 32'h0000_0077, 1'b0);
        tests[4] = make_test(enc_itype(12'd1, 5'd0, 3'b000, 5'd7, OP_IMM), 32'h0000_007f,
                             enc_stype(12'd0, 5'd7, 5'd0), ECALL,
                             32'hcafe_f00d, 32'd0, 32'hcafe_f00d, 1'b1);
        // store after ecall never runs
        tests[5] = make_test(enc_itype(12'h055, 5'd0, 3'b000, 5'd8, OP_IMM), ECALL,
                             enc_stype(12'd0, 5'd8, 5'd0), ECALL,
                             32'h1234_5678, 32'd0, 32'h1234_5678, 1'b0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            err_before = errors;
            reset_and_load(tests[t]);
            wait_halt(timed_out);
            if (timed_out) begin
                $display("test %0d: core did not halt within %0d cycles", t, HALT_TIMEOUT);
                errors++;
            end
            dbg_addr = tests[t].exp_addr;
            #1;
            check_value("dbg_data_o", dbg_data, tests[t].exp_data);
            check_value("illegal_o", {31'd0, illegal}, {31'd0, tests[t].exp_illegal});
            $display("test %0d finished with %0d errors", t, errors - err_before);
        end

        $display("%0d tests run, %0d errors", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sim/rv_core_checker.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module rv_core_checker
    import rv_core_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic [`RV_XLEN-1:0] pc_i,
    input ctrl_t               ctrl_i,
    input logic                halted_i,
    input logic                illegal_i
);

    // flags leave reset low
    assert property (@(posedge clk) !rst_n |=> (!halted_i && !illegal_i))
        else $error("halted_o or illegal_o high after reset");

    // halt is sticky until reset
    assert property (@(posedge clk) (rst_n && halted_i) |=> halted_i)
        else $error("halted_o fell without reset");

    // pc register frozen once halted
    assert property (@(posedge clk) (rst_n && halted_i) |=> $stable(pc_i))
        else $error("pc changed while halted");

    assert property (@(posedge clk) disable iff (!rst_n) pc_i[1:0] == 2'b00)
        else $error("pc not word aligned: 0x%08h", pc_i);

endmodule

bind core_ctrl rv_core_checker i_rv_core_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_i      (pc_o),
    .ctrl_i    (ctrl_o),
    .halted_i  (halted_o),
    .illegal_i (illegal_o)
);

// File: hdl/rv_core_top.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module rv_core_top
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load_we_i,
    input  logic                load_dmem_i,
    input  logic [`RV_XLEN-1:0] load_addr_i,
    input  logic [`RV_XLEN-1:0] load_data_i,
    input  logic [`RV_XLEN-1:0] dbg_addr_i,
    output logic [`RV_XLEN-1:0] dbg_data_o,
    output logic                halted_o,
    output logic                illegal_o
);

    logic [`RV_XLEN-1:0] pc;
    rv_inst_t            inst;
    ctrl_t               ctrl;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] dmem_rdata;
    logic [`RV_XLEN-1:0] wb_data;

    core_ctrl i_core_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_i    (inst),
        .pc_o      (pc),
        .ctrl_o    (ctrl),
        .halted_o  (halted_o),
        .illegal_o (illegal_o)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_i     (ctrl),
        .wb_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    exec_unit i_exec_unit (
        .inst_i     (inst),
        .ctrl_i     (ctrl),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .result_o   (alu_result)
    );

    rv_memory i_rv_memory (
        .clk         (clk),
        .pc_i        (pc),
        .inst_o      (inst),
        .ctrl_i      (ctrl),
        .daddr_i     (alu_result),
        .wdata_i     (rs2_data),
        .rdata_o     (dmem_rdata),
        .load_we_i   (load_we_i),
        .load_dmem_i (load_dmem_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .dbg_addr_i  (dbg_addr_i),
        .dbg_data_o  (dbg_data_o)
    );

    // loads write back memory data, everything else the adder
    assign wb_data = ctrl.wb_from_mem ? dmem_rdata : alu_result;

endmodule

// File: hdl/rv_memory.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module rv_memory
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic                clk,
    input  logic [`RV_XLEN-1:0] pc_i,
    output rv_inst_t            inst_o,
    input  ctrl_t               ctrl_i,
    input  logic [`RV_XLEN-1:0] daddr_i,
    input  logic [`RV_XLEN-1:0] wdata_i,
    output logic [`RV_XLEN-1:0] rdata_o,
    input  logic                load_we_i,
    input  logic                load_dmem_i,
    input  logic [`RV_XLEN-1:0] load_addr_i,
    input  logic [`RV_XLEN-1:0] load_data_i,
    input  logic [`RV_XLEN-1:0] dbg_addr_i,
    output logic [`RV_XLEN-1:0] dbg_data_o
);

    logic [`RV_XLEN-1:0] imem [`RV_MEM_WORDS];
    logic [`RV_XLEN-1:0] dmem [`RV_MEM_WORDS];

    // byte address to word index, upper bits wrap
    function automatic logic [`RV_MEM_AW-1:0] word_idx(input logic [`RV_XLEN-1:0] byte_addr);
        return byte_addr[`RV_MEM_AW+1:2];
    endfunction

    // load port takes priority over a core store
    always_ff @(posedge clk) begin
        if (load_we_i) begin
            if (load_dmem_i) begin
                dmem[word_idx(load_addr_i)] <= load_data_i;
            end else begin
                imem[word_idx(load_addr_i)] <= load_data_i;
            end
        end else if (ctrl_i.mem_we) begin
            dmem[word_idx(daddr_i)] <= wdata_i;
        end
    end

    assign inst_o     = imem[word_idx(pc_i)];
    assign rdata_o    = dmem[word_idx(daddr_i)];
    assign dbg_data_o = dmem[word_idx(dbg_addr_i)];

endmodule

// File: hdl/exec_unit.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module exec_unit
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  rv_inst_t            inst_i,
    input  ctrl_t               ctrl_i,
    input  logic [`RV_XLEN-1:0] rs1_data_i,
    input  logic [`RV_XLEN-1:0] rs2_data_i,
    output logic [`RV_XLEN-1:0] result_o
);

    localparam int IMM_W = 12;

    logic [IMM_W-1:0]    imm_i;
    logic [IMM_W-1:0]    imm_s;
    logic [`RV_XLEN-1:0] imm_i_sext;
    logic [`RV_XLEN-1:0] imm_s_sext;
    logic [`RV_XLEN-1:0] operand_b;

    // I-type immediate sits in funct7 and rs2
    assign imm_i = {inst_i.funct7, inst_i.rs2};
    // S-type splits it across funct7 and rd
    assign imm_s = {inst_i.funct7, inst_i.rd};

    assign imm_i_sext = {{(`RV_XLEN-IMM_W){imm_i[IMM_W-1]}}, imm_i};
    assign imm_s_sext = {{(`RV_XLEN-IMM_W){imm_s[IMM_W-1]}}, imm_s};

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD_IMM_I: operand_b = imm_i_sext;
            ALU_ADD_IMM_S: operand_b = imm_s_sext;
            ALU_ADD_REG:   operand_b = rs2_data_i;
            default:       operand_b = '0;
        endcase
    end

    // wraps modulo 2^32
    assign result_o = rs1_data_i + operand_b;

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module reg_file
    import rv_core_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  ctrl_t               ctrl_i,
    input  logic [`RV_XLEN-1:0] wb_data_i,
    output logic [`RV_XLEN-1:0] rs1_data_o,
    output logic [`RV_XLEN-1:0] rs2_data_o
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl_i.reg_we && (ctrl_i.rd != '0)) begin
            regs[ctrl_i.rd] <= wb_data_i;
        end
    end

    always_comb begin
        if (ctrl_i.rs1 == '0) begin
            rs1_data_o = '0;
        end else begin
            rs1_data_o = regs[ctrl_i.rs1];
        end
    end

    always_comb begin
        if (ctrl_i.rs2 == '0) begin
            rs2_data_o = '0;
        end else begin
            rs2_data_o = regs[ctrl_i.rs2];
        end
    end

endmodule

// File: hdl/core_ctrl.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module core_ctrl
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  rv_inst_t            inst_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output ctrl_t               ctrl_o,
    output logic                halted_o,
    output logic                illegal_o
);

    logic [`RV_XLEN-1:0] pc_q;
    core_state_e         state_q;
    logic                illegal_q;
    ctrl_t               dec;
    logic                is_ecall;
    logic                is_legal;

    always_comb begin
        dec          = '0;
        dec.alu_op   = ALU_ADD_IMM_I;
        dec.rs1      = inst_i.rs1;
        dec.rs2      = inst_i.rs2;
        dec.rd       = inst_i.rd;
        is_ecall     = 1'b0;
        is_legal     = 1'b1;
        case (inst_i.opcode)
            OPC_LOAD: begin
                is_legal        = (inst_i.funct3 == RV_F3_WORD);
                dec.reg_we      = is_legal;
                dec.wb_from_mem = is_legal;
            end
            OPC_STORE: begin
                is_legal   = (inst_i.funct3 == RV_F3_WORD);
                dec.alu_op = ALU_ADD_IMM_S;
                dec.mem_we = is_legal;
            end
            OPC_OP_IMM: begin
                is_legal   = (inst_i.funct3 == RV_F3_ADD);
                dec.reg_we = is_legal;
            end
            OPC_OP: begin
                is_legal   = (inst_i.funct3 == RV_F3_ADD) && (inst_i.funct7 == 7'd0);
                dec.alu_op = ALU_ADD_REG;
                dec.reg_we = is_legal;
            end
            OPC_SYSTEM: begin
                // only the all-zero ecall form is accepted
                is_ecall = ({inst_i.funct7, inst_i.rs2, inst_i.rs1,
                             inst_i.funct3, inst_i.rd} == '0);
                is_legal = is_ecall;
            end
            default: is_legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q      <= '0;
            state_q   <= ST_RUN;
            illegal_q <= 1'b0;
        end else if (state_q == ST_RUN) begin
            if (!is_legal) begin
                state_q   <= ST_HALT;
                illegal_q <= 1'b1;
            end else if (is_ecall) begin
                state_q <= ST_HALT;
            end else begin
                pc_q <= pc_q + `RV_XLEN'd4;
            end
        end
    end

    // halted core keeps decoding but commits nothing
    always_comb begin
        ctrl_o        = dec;
        ctrl_o.reg_we = dec.reg_we && (state_q == ST_RUN);
        ctrl_o.mem_we = dec.mem_we && (state_q == ST_RUN);
    end

    assign pc_o      = pc_q;
    assign halted_o  = (state_q == ST_HALT);
    assign illegal_o = illegal_q;

endmodule

// File: hdl/rv_core_pkg.sv
`include "rv_consts.svh"

package rv_core_pkg;

    // adder operand selection
    typedef enum logic [1:0] {
        ALU_ADD_IMM_I = 2'd0,
        ALU_ADD_IMM_S = 2'd1,
        ALU_ADD_REG   = 2'd2
    } alu_op_e;

    typedef enum logic {
        ST_RUN  = 1'b0,
        ST_HALT = 1'b1
    } core_state_e;

    // decoded controls for one instruction
    typedef struct packed {
        alu_op_e                alu_op;
        logic                   reg_we;
        logic                   wb_from_mem;
        logic                   mem_we;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rd;
    } ctrl_t;

endpackage

// File: hdl/rv_isa_pkg.sv
`include "rv_consts.svh"

package rv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    // funct3 for word loads and stores
    localparam logic [2:0] RV_F3_WORD = 3'b010;
    // funct3 for add and addi
    localparam logic [2:0] RV_F3_ADD = 3'b000;

    // R-type field layout; I and S immediates are rebuilt from these fields
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [2:0]             funct3;
        logic [`RV_REG_AW-1:0]  rd;
        rv_opcode_e             opcode;
    } rv_inst_t;

endpackage

// File: hdl/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath word width
`define RV_XLEN 32

// integer register file
`define RV_REG_COUNT 32
`define RV_REG_AW 5

// each memory holds this many words
`define RV_MEM_WORDS 256
`define RV_MEM_AW 8

`endif
